// ==== rtl/clk_mgmt_pkg.sv ====
package clk_mgmt_pkg;

    localparam int PHASE_W    = 9;  // phase-shift tile step range
    localparam int MD_W       = 8;  // multiply / divide field width
    localparam int ADCSRC_W   = 3;  // adc clock mux select bits
    localparam int REG_ADDR_W = 3;
    localparam int REG_DATA_W = 16;

    // host register map
    localparam logic [REG_ADDR_W-1:0] ADDR_PHASE   = 3'd0;  // target phase, low 9 bits
    localparam logic [REG_ADDR_W-1:0] ADDR_CLKGEN  = 3'd1;  // {mul, div}, write starts load
    localparam logic [REG_ADDR_W-1:0] ADDR_SOURCE  = 3'd2;  // {clkgen src, adc src}
    localparam logic [REG_ADDR_W-1:0] ADDR_CONTROL = 3'd3;  // bit 0 pulses clkgen reset
    localparam logic [REG_ADDR_W-1:0] ADDR_STATUS  = 3'd4;  // read only

    // clkgen programming frame prefixes, sent lsb first
    localparam logic [1:0] PROG_CODE_D  = 2'b01;
    localparam logic [1:0] PROG_CODE_M  = 2'b11;
    localparam int         PROG_GAP_CYC = 2;  // progen low cycles between frames

    typedef enum logic [2:0] {
        OP_NONE,
        OP_SET_PHASE,
        OP_LOAD_CLKGEN,
        OP_SET_SOURCE,
        OP_CLKGEN_RESET
    } clk_op_e;

    typedef struct packed {
        logic                  valid;  // one cycle strobe
        clk_op_e               op;
        logic [REG_DATA_W-1:0] arg;    // raw write data
    } clk_cmd_t;

    typedef struct packed {
        logic                gen;  // clkgen input select, bit 3
        logic [ADCSRC_W-1:0] adc;  // adc clock path select, bits 2..0
    } clk_src_t;

    typedef enum logic [1:0] {
        PS_IDLE,
        PS_STEP,
        PS_WAIT_DONE
    } phase_state_e;

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_SHIFT,
        LD_GAP,
        LD_GO,
        LD_WAIT_DONE
    } load_state_e;

    typedef struct packed {
        logic phase_busy;
        logic phase_done;
        logic clkgen_busy;
        logic clkgen_done;
        logic adc_locked;
        logic gen_locked;
    } clk_stat_t;

endpackage

// ==== rtl/clk_cmd_decode.sv ====
`timescale 1ns/10ps

module clk_cmd_decode (
    input  logic                                clk_usb_i,
    input  logic                                arst_n_i,
    input  logic                                wr_i,     // single cycle write strobe
    input  logic [clk_mgmt_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [clk_mgmt_pkg::REG_DATA_W-1:0] wdata_i,
    output clk_mgmt_pkg::clk_cmd_t              cmd_o,    // typed command, one cycle after wr_i
    output clk_mgmt_pkg::clk_src_t              src_o     // registered clock source selects
);
    import clk_mgmt_pkg::*;

    clk_op_e op;  // opcode for the current address

    always_comb begin
        case (addr_i)
            ADDR_PHASE:   op = OP_SET_PHASE;
            ADDR_CLKGEN:  op = OP_LOAD_CLKGEN;
            ADDR_SOURCE:  op = OP_SET_SOURCE;
            ADDR_CONTROL: op = wdata_i[0] ? OP_CLKGEN_RESET : OP_NONE;  // only bit 0 acts
            default:      op = OP_NONE;  // status and unused addresses
        endcase
    end

    always_ff @(posedge clk_usb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cmd_o <= '0;
        end else begin
            cmd_o.valid <= wr_i && (op != OP_NONE);
            cmd_o.op    <= wr_i ? op : OP_NONE;
            cmd_o.arg   <= wdata_i;
        end
    end

    // source select register, both muxes default to input 0
    always_ff @(posedge clk_usb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_o <= '0;
        end else if (wr_i && op == OP_SET_SOURCE) begin
            src_o <= clk_src_t'(wdata_i[ADCSRC_W:0]);  // bit 3 gen, bits 2..0 adc
        end
    end

endmodule

// ==== rtl/phase_step_ctrl.sv ====
`timescale 1ns/10ps

module phase_step_ctrl (
    input  logic                             clk_usb_i,
    input  logic                             arst_n_i,
    input  clk_mgmt_pkg::clk_cmd_t           cmd_i,
    output logic                             psen_o,      // one cycle step request
    output logic                             psincdec_o,  // 1 = increment
    input  logic                             psdone_i,    // tile ack, variable latency
    output logic [clk_mgmt_pkg::PHASE_W-1:0] phase_o,     // actual tile phase
    output logic                             busy_o,
    output logic                             done_o
);
    import clk_mgmt_pkg::*;

    phase_state_e       state_q;
    logic [PHASE_W-1:0] target_q;  // requested phase
    logic [PHASE_W-1:0] phase_q;   // phase the tile has reached
    logic               dir_q;     // direction of the step in flight

    always_ff @(posedge clk_usb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= PS_IDLE;
            target_q <= '0;
            phase_q  <= '0;
            dir_q    <= 1'b0;
        end else begin
            // a new target is taken at any time, the step in flight still finishes
            if (cmd_i.valid && cmd_i.op == OP_SET_PHASE) begin
                target_q <= cmd_i.arg[PHASE_W-1:0];
            end
            case (state_q)
                PS_IDLE: begin
                    if (phase_q != target_q) begin
                        dir_q   <= target_q > phase_q;  // head toward target
                        state_q <= PS_STEP;
                    end
                end
                PS_STEP: state_q <= PS_WAIT_DONE;  // psen_o high this cycle
                PS_WAIT_DONE: begin
                    if (psdone_i) begin
                        phase_q <= dir_q ? phase_q + 1'b1 : phase_q - 1'b1;
                        state_q <= PS_IDLE;  // re-check against a possibly new target
                    end
                end
                default: state_q <= PS_IDLE;
            endcase
        end
    end

    assign psen_o     = (state_q == PS_STEP);
    assign psincdec_o = dir_q;  // set on entry to PS_STEP, stable for the pulse
    assign phase_o    = phase_q;
    assign busy_o     = (state_q != PS_IDLE);
    assign done_o     = (state_q == PS_IDLE) && (phase_q == target_q);

endmodule

// ==== rtl/clkgen_prog_loader.sv ====
`timescale 1ns/10ps

module clkgen_prog_loader (
    input  logic                            clk_usb_i,
    input  logic                            arst_n_i,
    input  clk_mgmt_pkg::clk_cmd_t          cmd_i,
    output logic                            progen_o,        // frame enable / go pulse
    output logic                            progdata_o,      // serial data, lsb first
    input  logic                            progdone_i,      // tile finished reprogramming
    output logic [2*clk_mgmt_pkg::MD_W-1:0] md_o,            // last accepted {mul, div}
    output logic                            busy_o,
    output logic                            done_o,
    output logic                            clkgen_reset_o   // one cycle tile reset
);
    import clk_mgmt_pkg::*;

    load_state_e       state_q;
    logic [3:0]        cnt_q;      // bit counter in a frame, cycle counter in a gap
    logic              frame_m_q;  // 0 = divide frame, 1 = multiply frame
    logic [2*MD_W-1:0] md_q;
    logic              done_q;
    logic [MD_W+1:0]   shift_q;    // {value-1, prefix}, shifted out from bit 0
    logic              load_cmd;
    logic              frame_end;
    logic              gap_end;
    logic [MD_W-1:0]   div_m1;
    logic [MD_W-1:0]   mul_m1;

    assign load_cmd  = cmd_i.valid && (cmd_i.op == OP_LOAD_CLKGEN);
    assign frame_end = (state_q == LD_SHIFT) && (cnt_q == 4'(MD_W + 1));  // 10th bit
    assign gap_end   = (state_q == LD_GAP) && (cnt_q == 4'(PROG_GAP_CYC - 1));
    assign div_m1    = cmd_i.arg[MD_W-1:0] - 1'b1;   // tile takes D-1
    assign mul_m1    = md_q[2*MD_W-1:MD_W] - 1'b1;  // and M-1

    always_ff @(posedge clk_usb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= LD_IDLE;
            cnt_q          <= '0;
            frame_m_q      <= 1'b0;
            md_q           <= '0;
            done_q         <= 1'b1;  // nothing pending after reset
            clkgen_reset_o <= 1'b0;
        end else begin
            clkgen_reset_o <= cmd_i.valid && (cmd_i.op == OP_CLKGEN_RESET);
            case (state_q)
                LD_IDLE: begin
                    if (load_cmd) begin  // loads while busy are dropped
                        md_q      <= cmd_i.arg;
                        frame_m_q <= 1'b0;
                        cnt_q     <= '0;
                        done_q    <= 1'b0;
                        state_q   <= LD_SHIFT;
                    end
                end
                LD_SHIFT: begin
                    cnt_q <= frame_end ? '0 : cnt_q + 1'b1;
                    if (frame_end) begin
                        state_q <= LD_GAP;
                    end
                end
                LD_GAP: begin
                    cnt_q <= gap_end ? '0 : cnt_q + 1'b1;
                    if (gap_end) begin
                        frame_m_q <= 1'b1;
                        state_q   <= frame_m_q ? LD_GO : LD_SHIFT;  // M frame after D frame
                    end
                end
                LD_GO: state_q <= LD_WAIT_DONE;  // single go cycle
                LD_WAIT_DONE: begin
                    if (progdone_i) begin
                        done_q  <= 1'b1;
                        state_q <= LD_IDLE;
                    end
                end
                default: state_q <= LD_IDLE;
            endcase
        end
    end

    // frame shifter
    always_ff @(posedge clk_usb_i) begin
        if (state_q == LD_IDLE && load_cmd) begin
            shift_q <= {div_m1, PROG_CODE_D};
        end else if (gap_end && !frame_m_q) begin
            shift_q <= {mul_m1, PROG_CODE_M};
        end else if (state_q == LD_SHIFT) begin
            shift_q <= {1'b0, shift_q[MD_W+1:1]};
        end
    end

    assign progen_o   = (state_q == LD_SHIFT) || (state_q == LD_GO);
    assign progdata_o = (state_q == LD_SHIFT) && shift_q[0];  // low during go
    assign md_o       = md_q;
    assign busy_o     = (state_q != LD_IDLE);
    assign done_o     = done_q;

endmodule

// ==== rtl/clk_status_result.sv ====
`timescale 1ns/10ps

module clk_status_result (
    input  logic                                clk_usb_i,
    input  logic                                arst_n_i,
    input  logic                                rd_i,                 // single cycle read strobe
    input  logic [clk_mgmt_pkg::REG_ADDR_W-1:0] raddr_i,
    input  logic [clk_mgmt_pkg::PHASE_W-1:0]    phase_i,
    input  logic                                phase_busy_i,
    input  logic                                phase_done_i,
    input  logic [2*clk_mgmt_pkg::MD_W-1:0]     md_i,
    input  clk_mgmt_pkg::clk_src_t              src_i,
    input  logic                                clkgen_busy_i,
    input  logic                                clkgen_done_i,
    input  logic                                adc_locked_raw_i,     // tile lock flag
    input  logic                                adc_clkin_stopped_i,  // tile input clock lost
    input  logic                                gen_locked_raw_i,
    input  logic                                gen_clkin_stopped_i,
    output logic                                adc_locked_o,
    output logic                                gen_locked_o,
    output logic [clk_mgmt_pkg::REG_DATA_W-1:0] rdata_o,
    output logic                                rvalid_o              // one cycle after rd_i
);
    import clk_mgmt_pkg::*;

    clk_stat_t stat;

    // locked alone can stay high with the input clock gone, so qualify it
    always_ff @(posedge clk_usb_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            adc_locked_o <= 1'b0;
            gen_locked_o <= 1'b0;
            rvalid_o     <= 1'b0;
        end else begin
            adc_locked_o <= adc_locked_raw_i && !adc_clkin_stopped_i;
            gen_locked_o <= gen_locked_raw_i && !gen_clkin_stopped_i;
            rvalid_o     <= rd_i;
        end
    end

    assign stat = '{phase_busy:  phase_busy_i,
                    phase_done:  phase_done_i,
                    clkgen_busy: clkgen_busy_i,
                    clkgen_done: clkgen_done_i,
                    adc_locked:  adc_locked_o,
                    gen_locked:  gen_locked_o};

    always_ff @(posedge clk_usb_i) begin
        if (rd_i) begin
            case (raddr_i)
                ADDR_PHASE:  rdata_o <= REG_DATA_W'(phase_i);  // actual, not target
                ADDR_CLKGEN: rdata_o <= REG_DATA_W'(md_i);
                ADDR_SOURCE: rdata_o <= REG_DATA_W'(src_i);
                ADDR_STATUS: rdata_o <= REG_DATA_W'(stat);     // low 6 bits
                default:     rdata_o <= '0;
            endcase
        end
    end

endmodule

// ==== rtl/clk_mgmt_ctrl_top.sv ====
`timescale 1ns/10ps

module clk_mgmt_ctrl_top (
    input  logic                                clk_usb_i,
    input  logic                                arst_n_i,
    // host register port
    input  logic                                wr_i,
    input  logic [clk_mgmt_pkg::REG_ADDR_W-1:0] addr_i,
    input  logic [clk_mgmt_pkg::REG_DATA_W-1:0] wdata_i,
    input  logic                                rd_i,
    input  logic [clk_mgmt_pkg::REG_ADDR_W-1:0] raddr_i,
    output logic [clk_mgmt_pkg::REG_DATA_W-1:0] rdata_o,
    output logic                                rvalid_o,
    // phase-shift tile
    output logic                                psen_o,
    output logic                                psincdec_o,
    input  logic                                psdone_i,
    // clkgen tile programming
    output logic                                progen_o,
    output logic                                progdata_o,
    input  logic                                progdone_i,
    output logic                                clkgen_reset_o,
    // clock mux selects and status
    output clk_mgmt_pkg::clk_src_t              src_o,
    output logic                                phase_done_o,
    output logic                                clkgen_done_o,
    input  logic                                adc_locked_i,
    input  logic                                adc_clkin_stopped_i,
    input  logic                                gen_locked_i,
    input  logic                                gen_clkin_stopped_i,
    output logic                                adc_locked_o,
    output logic                                gen_locked_o
);
    import clk_mgmt_pkg::*;

    clk_cmd_t            cmd;
    logic [PHASE_W-1:0]  phase;
    logic                phase_busy;
    logic [2*MD_W-1:0]   md;
    logic                clkgen_busy;

    clk_cmd_decode u_decode (
        .clk_usb_i (clk_usb_i),
        .arst_n_i  (arst_n_i),
        .wr_i      (wr_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .cmd_o     (cmd),
        .src_o     (src_o)
    );

    phase_step_ctrl u_phase (
        .clk_usb_i  (clk_usb_i),
        .arst_n_i   (arst_n_i),
        .cmd_i      (cmd),
        .psen_o     (psen_o),
        .psincdec_o (psincdec_o),
        .psdone_i   (psdone_i),
        .phase_o    (phase),
        .busy_o     (phase_busy),
        .done_o     (phase_done_o)
    );

    clkgen_prog_loader u_loader (
        .clk_usb_i      (clk_usb_i),
        .arst_n_i       (arst_n_i),
        .cmd_i          (cmd),
        .progen_o       (progen_o),
        .progdata_o     (progdata_o),
        .progdone_i     (progdone_i),
        .md_o           (md),
        .busy_o         (clkgen_busy),
        .done_o         (clkgen_done_o),
        .clkgen_reset_o (clkgen_reset_o)
    );

    clk_status_result u_status (
        .clk_usb_i           (clk_usb_i),
        .arst_n_i            (arst_n_i),
        .rd_i                (rd_i),
        .raddr_i             (raddr_i),
        .phase_i             (phase),
        .phase_busy_i        (phase_busy),
        .phase_done_i        (phase_done_o),
        .md_i                (md),
        .src_i               (src_o),
        .clkgen_busy_i       (clkgen_busy),
        .clkgen_done_i       (clkgen_done_o),
        .adc_locked_raw_i    (adc_locked_i),
        .adc_clkin_stopped_i (adc_clkin_stopped_i),
        .gen_locked_raw_i    (gen_locked_i),
        .gen_clkin_stopped_i (gen_clkin_stopped_i),
        .adc_locked_o        (adc_locked_o),
        .gen_locked_o        (gen_locked_o),
        .rdata_o             (rdata_o),
        .rvalid_o            (rvalid_o)
    );

endmodule

// ==== test/clk_mgmt_assertions.sv ====
`timescale 1ns/10ps

module clk_mgmt_assertions (
    input logic clk_i,
    input logic arst_n_i,
    input logic psen_i,
    input logic psdone_i,
    input logic progen_i,
    input logic clkgen_done_i
);
    logic step_open;  // psen sent, psdone not yet seen

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            step_open <= 1'b0;
        end else if (psen_i) begin
            step_open <= 1'b1;
        end else if (psdone_i) begin
            step_open <= 1'b0;
        end
    end

    a_one_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        psen_i |-> !step_open)
        else $error("psen_o pulsed again before psdone_i");

    a_no_x: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown({psen_i, progen_i}))
        else $error("psen_o or progen_o unknown");

    a_done_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        progen_i |-> !clkgen_done_i)
        else $error("clkgen_done_o high while programming");

endmodule

bind clk_mgmt_ctrl_top clk_mgmt_assertions u_assertions (
    .clk_i         (clk_usb_i),
    .arst_n_i      (arst_n_i),
    .psen_i        (psen_o),
    .psdone_i      (psdone_i),
    .progen_i      (progen_o),
    .clkgen_done_i (clkgen_done_o)
);

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,     // clk_usb
    output logic arst_n_o   // active low reset
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;  // 8 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);  // hold reset 5 cycles
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== test/tb_clk_mgmt.sv ====
`timescale 1ns/10ps

module tb_clk_mgmt;
    import clk_mgmt_pkg::*;

    logic                  clk_usb;
    logic                  arst_n;
    logic                  wr;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
    logic                  rd;
    logic [REG_ADDR_W-1:0] raddr;
    logic [REG_DATA_W-1:0] rdata;
    logic                  rvalid;
    logic                  psen;
    logic                  psincdec;
    logic                  psdone;
    logic                  progen;
    logic                  progdata;
    logic                  progdone;
    logic                  clkgen_reset;
    clk_src_t              src;
    logic                  phase_done;
    logic                  clkgen_done;
    logic                  adc_locked_in;  // raw tile flags
    logic                  adc_stopped;
    logic                  gen_locked_in;
    logic                  gen_stopped;
    logic                  adc_locked;     // qualified flags
    logic                  gen_locked;
    int                    inc_cnt;        // psen pulses by direction
    int                    dec_cnt;

    tb_clock_gen u_clock_gen (
        .clk_o    (clk_usb),
        .arst_n_o (arst_n)
    );

    clk_mgmt_ctrl_top u_clk_mgmt_ctrl_top (
        .clk_usb_i           (clk_usb),
        .arst_n_i            (arst_n),
        .wr_i                (wr),
        .addr_i              (addr),
        .wdata_i             (wdata),
        .rd_i                (rd),
        .raddr_i             (raddr),
        .rdata_o             (rdata),
        .rvalid_o            (rvalid),
        .psen_o              (psen),
        .psincdec_o          (psincdec),
        .psdone_i            (psdone),
        .progen_o            (progen),
        .progdata_o          (progdata),
        .progdone_i          (progdone),
        .clkgen_reset_o      (clkgen_reset),
        .src_o               (src),
        .phase_done_o        (phase_done),
        .clkgen_done_o       (clkgen_done),
        .adc_locked_i        (adc_locked_in),
        .adc_clkin_stopped_i (adc_stopped),
        .gen_locked_i        (gen_locked_in),
        .gen_clkin_stopped_i (gen_stopped),
        .adc_locked_o        (adc_locked),
        .gen_locked_o        (gen_locked)
    );

    // phase-shift tile model, psdone 1..6 cycles after each psen
    initial begin : phase_tile
        int lat;
        psdone = 1'b0;
        forever begin
            @(negedge clk_usb);
            if (psen === 1'b1) begin
                lat = $urandom_range(6, 1);
                repeat (lat) @(negedge clk_usb);
                psdone = 1'b1;
                @(negedge clk_usb);
                psdone = 1'b0;
            end
        end
    end

    // clkgen tile model, a one cycle progen run is the go pulse
    initial begin : clkgen_tile
        int run;
        int lat;
        progdone = 1'b0;
        run      = 0;
        forever begin
            @(negedge clk_usb);
            if (progen === 1'b1) begin
                run++;
            end else begin
                if (run == 1) begin
                    lat = $urandom_range(6, 1);
                    repeat (lat - 1) @(negedge clk_usb);
                    progdone = 1'b1;
                    @(negedge clk_usb);
                    progdone = 1'b0;
                end
                run = 0;
            end
        end
    end

    always @(negedge clk_usb) begin
        if (arst_n !== 1'b1) begin
            inc_cnt = 0;
            dec_cnt = 0;
        end else if (psen) begin
            if (psincdec) inc_cnt++;
            else dec_cnt++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] a, input logic [REG_DATA_W-1:0] d);
        @(negedge clk_usb);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk_usb);
        wr    = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] a, output logic [REG_DATA_W-1:0] d);
        @(negedge clk_usb);
        rd    = 1'b1;
        raddr = a;
        @(negedge clk_usb);
        rd = 1'b0;
        check_value("rvalid_o", 32'(rvalid), 32'h1);  // exactly one cycle after rd_i
        d = rdata;
        @(negedge clk_usb);
        check_value("rvalid_o", 32'(rvalid), 32'h0);
    endtask

    task automatic expect_reg(input logic [REG_ADDR_W-1:0] a,
                              input logic [REG_DATA_W-1:0] exp, input string name);
        logic [REG_DATA_W-1:0] d;
        read_reg(a, d);
        check_value(name, 32'(d), 32'(exp));
    endtask

    task automatic wait_phase_done();
        int cycles;
        cycles = 0;
        @(negedge clk_usb);  // new target lands a cycle after the command
        while (!phase_done && cycles < 4000) begin
            cycles++;
            @(negedge clk_usb);
        end
        if (!phase_done) report_timeout("phase_done_o");
    endtask

    task automatic capture_frame(output logic [9:0] bits);
        for (int i = 0; i < 10; i++) begin
            check_value("progen_o in frame", 32'(progen), 32'h1);
            bits[i] = progdata;  // lsb first
            @(negedge clk_usb);
        end
    endtask

    task automatic check_gap();
        repeat (2) begin
            check_value("progen_o in gap", 32'(progen), 32'h0);
            @(negedge clk_usb);
        end
    endtask

    task automatic test_reset_defaults();
        check_value("psen_o", 32'(psen), 32'h0);
        check_value("progen_o", 32'(progen), 32'h0);
        check_value("clkgen_reset_o", 32'(clkgen_reset), 32'h0);
        check_value("rvalid_o", 32'(rvalid), 32'h0);
        check_value("src_o", 32'(src), 32'h0);
        check_value("phase_done_o", 32'(phase_done), 32'h1);
        check_value("clkgen_done_o", 32'(clkgen_done), 32'h1);
        expect_reg(ADDR_PHASE, 16'h0, "rdata_o phase");
        expect_reg(ADDR_SOURCE, 16'h0, "rdata_o source");
    endtask

    task automatic test_phase_step();
        int inc0;
        int dec0;
        inc0 = inc_cnt;
        dec0 = dec_cnt;
        write_reg(ADDR_PHASE, 16'd37);
        wait_phase_done();
        check_value("increments", 32'(inc_cnt - inc0), 32'd37);
        check_value("decrements", 32'(dec_cnt - dec0), 32'd0);
        expect_reg(ADDR_PHASE, 16'd37, "rdata_o phase");
        inc0 = inc_cnt;
        dec0 = dec_cnt;
        write_reg(ADDR_PHASE, 16'd30);
        wait_phase_done();
        check_value("increments", 32'(inc_cnt - inc0), 32'd0);
        check_value("decrements", 32'(dec_cnt - dec0), 32'd7);
        expect_reg(ADDR_PHASE, 16'd30, "rdata_o phase");
    endtask

    task automatic test_phase_retarget();
        logic [REG_DATA_W-1:0] start;
        int inc0;
        int dec0;
        int cycles;
        read_reg(ADDR_PHASE, start);
        inc0   = inc_cnt;
        dec0   = dec_cnt;
        cycles = 0;
        write_reg(ADDR_PHASE, 16'd100);
        while (inc_cnt < inc0 + 4 && cycles < 200) begin  // let a few steps go
            cycles++;
            @(negedge clk_usb);
        end
        if (inc_cnt < inc0 + 4) report_timeout("steps toward 100");
        write_reg(ADDR_PHASE, 16'd20);
        wait_phase_done();
        expect_reg(ADDR_PHASE, 16'd20, "rdata_o phase");
        check_value("net steps", 32'((inc_cnt - inc0) - (dec_cnt - dec0)),
                    32'(20 - int'(start)));
        check_value("turned around", 32'(dec_cnt > dec0), 32'h1);
    endtask

    task automatic test_clkgen_load();
        logic [7:0]            mul;
        logic [7:0]            div;
        logic [9:0]            frame_d;
        logic [9:0]            frame_m;
        logic [REG_DATA_W-1:0] word;
        clk_stat_t             stat;
        int                    cycles;
        mul    = 8'd5;
        div    = 8'd3;
        cycles = 0;
        write_reg(ADDR_CLKGEN, {mul, div});
        while (!progen && cycles < 20) begin
            cycles++;
            @(negedge clk_usb);
        end
        if (!progen) report_timeout("progen_o");
        check_value("clkgen_done_o", 32'(clkgen_done), 32'h0);
        fork
            begin
                capture_frame(frame_d);
                check_gap();
                capture_frame(frame_m);
                check_gap();
                check_value("progen_o go", 32'(progen), 32'h1);
                check_value("progdata_o go", 32'(progdata), 32'h0);
                @(negedge clk_usb);
                check_value("progen_o after go", 32'(progen), 32'h0);
            end
            begin
                repeat (4) @(negedge clk_usb);
                write_reg(ADDR_CLKGEN, {8'd9, 8'd7});  // loader busy, must be dropped
                read_reg(ADDR_STATUS, word);           // still inside the D frame
                stat = clk_stat_t'(word[5:0]);
                check_value("status clkgen_busy", 32'(stat.clkgen_busy), 32'h1);
                check_value("status clkgen_done", 32'(stat.clkgen_done), 32'h0);
            end
        join
        check_value("progdata_o D frame", 32'(frame_d), 32'({div - 8'd1, 2'b01}));
        check_value("progdata_o M frame", 32'(frame_m), 32'({mul - 8'd1, 2'b11}));
        cycles = 0;
        while (!clkgen_done && cycles < 20) begin
            cycles++;
            @(negedge clk_usb);
        end
        if (!clkgen_done) report_timeout("clkgen_done_o");
        expect_reg(ADDR_CLKGEN, {mul, div}, "rdata_o clkgen");
    endtask

    task automatic test_source_control();
        int cycles;
        cycles = 0;
        write_reg(ADDR_SOURCE, 16'h000b);
        check_value("src_o", 32'(src), 32'hb);
        expect_reg(ADDR_SOURCE, 16'h000b, "rdata_o source");
        write_reg(ADDR_CONTROL, 16'h0001);
        while (!clkgen_reset && cycles < 4) begin
            cycles++;
            @(negedge clk_usb);
        end
        if (!clkgen_reset) report_timeout("clkgen_reset_o");
        @(negedge clk_usb);
        check_value("clkgen_reset_o", 32'(clkgen_reset), 32'h0);  // single cycle
    endtask

    task automatic test_lock_qual();
        logic [3:0]            combo;  // {gen stopped, gen locked, adc stopped, adc locked}
        logic [REG_DATA_W-1:0] word;
        clk_stat_t             stat;
        for (int i = 0; i < 16; i++) begin
            combo         = 4'(i);
            adc_locked_in = combo[0];
            adc_stopped   = combo[1];
            gen_locked_in = combo[2];
            gen_stopped   = combo[3];
            @(negedge clk_usb);  // one register stage
            check_value("adc_locked_o", 32'(adc_locked), 32'(combo[0] & ~combo[1]));
            check_value("gen_locked_o", 32'(gen_locked), 32'(combo[2] & ~combo[3]));
            read_reg(ADDR_STATUS, word);
            stat = clk_stat_t'(word[5:0]);
            check_value("status adc_locked", 32'(stat.adc_locked), 32'(combo[0] & ~combo[1]));
            check_value("status gen_locked", 32'(stat.gen_locked), 32'(combo[2] & ~combo[3]));
            check_value("status phase_done", 32'(stat.phase_done), 32'h1);
            check_value("status clkgen_done", 32'(stat.clkgen_done), 32'h1);
            check_value("status phase_busy", 32'(stat.phase_busy), 32'h0);
            check_value("status clkgen_busy", 32'(stat.clkgen_busy), 32'h0);
        end
    endtask

    initial begin
        int cycles;
        void'($urandom(32'h18f4));  // single seed for the run
        wr            = 1'b0;
        addr          = '0;
        wdata         = '0;
        rd            = 1'b0;
        raddr         = '0;
        adc_locked_in = 1'b0;
        adc_stopped   = 1'b0;
        gen_locked_in = 1'b0;
        gen_stopped   = 1'b0;
        cycles        = 0;
        while (arst_n !== 1'b1 && cycles < 20) begin
            cycles++;
            @(negedge clk_usb);
        end
        if (arst_n !== 1'b1) report_timeout("reset release");
        @(negedge clk_usb);
        test_reset_defaults();
        test_phase_step();
        test_phase_retarget();
        test_clkgen_load();
        test_source_control();
        test_lock_qual();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/clk_mgmt_pkg.sv
rtl/clk_cmd_decode.sv
rtl/phase_step_ctrl.sv
rtl/clkgen_prog_loader.sv
rtl/clk_status_result.sv
rtl/clk_mgmt_ctrl_top.sv
test/clk_mgmt_assertions.sv
test/tb_clock_gen.sv
test/tb_clk_mgmt.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, the simulator exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_clk_mgmt \
    -o sim_clk_mgmt

./obj_dir/sim_clk_mgmt
